/* verilog/ps_pio_pkg.sv */
/*
 * programmable i/o channel common definitions
 * register offsets, command field widths and the command word layout
 */
`default_nettype none

package ps_pio_pkg;

    localparam logic [4:0] reg_en_rst       = 5'd0; // enable / channel reset
    localparam logic [4:0] reg_cmd          = 5'd1; // sequence command queue
    localparam logic [4:0] reg_status_cntrl = 5'd2; // status mode and seq number

    localparam int seq_addr_bits = 10;              // sequencer program address
    localparam int page_bits     = 2;               // buffer page number
    localparam int cmd_bits      = seq_addr_bits + page_bits + 3; // queue entry, 15

    // word written to reg_cmd
    typedef struct packed {
        logic [31-cmd_bits:0]     unused;
        logic                     cmd_wait; // hold until earlier transfers done
        logic                     wr;       // memory write from buffer
        logic                     need;     // urgent request
        logic [page_bits-1:0]     page;
        logic [seq_addr_bits-1:0] seq_addr;
    } seq_cmd_t;

    // word written to reg_en_rst
    typedef struct packed {
        logic [29:0] unused;
        logic        en;   // enable requests
        logic        nrst; // low holds channel in reset
    } en_rst_t;

    typedef union packed {
        seq_cmd_t cmd;
        en_rst_t  ctl;
    } cmd_word_t;

endpackage

`default_nettype wire

/* verilog/cmd_deser.sv */
/*
 * byte-serial command deserializer
 * six bytes per write: address low/high, then data bytes 0..3,
 * address filtered by base and mask
 */
`default_nettype none
`timescale 1ns/1ps

module cmd_deser #(
    parameter logic [15:0] ps_addr = 16'h0100,
    parameter logic [15:0] ps_mask = 16'h03e0
) (
    input  wire logic           rst,  // clock
    input  wire logic           mclk, // async reset, active high
    input  wire logic [7:0]     ad,   // serial address/data byte
    input  wire logic           stb,  // marks first byte
    output logic [4:0]          addr, // register offset in window
    output ps_pio_pkg::cmd_word_t data,
    output logic                we    // one cycle write strobe
);

    logic [2:0]  byte_cnt; // 0 idle, 1..5 collecting
    logic [47:0] sr;       // byte 0 ends up in [7:0]
    logic        last;     // all six bytes in
    logic        hit;      // masked address match

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            byte_cnt <= 3'd0;
            last     <= 1'b0;
        end else begin
            last <= (byte_cnt == 3'd5);   // byte 5 this cycle
            if (stb) begin
                byte_cnt <= 3'd1;         // restart on any strobe
            end else if (byte_cnt != 3'd0) begin
                byte_cnt <= (byte_cnt == 3'd5) ? 3'd0 : byte_cnt + 3'd1;
            end
        end
    end

    // shift only while a message is in flight, holds during we
    always_ff @(posedge rst) begin
        if (stb || (byte_cnt != 3'd0)) begin
            sr <= {ad, sr[47:8]};
        end
    end

    assign hit  = ((sr[15:0] ^ ps_addr) & ps_mask) == 16'h0000;
    assign we   = last && hit;
    assign addr = sr[4:0];     // low address bits select register
    assign data = sr[47:16];   // data byte 0 in bits 7:0

endmodule

`default_nettype wire

/* verilog/seq_issue.sv */
/*
 * sequence command issue
 * enable/reset register, command queue, arbiter requests,
 * sequencer hand-off and pending transfer count
 */
`default_nettype none
`timescale 1ns/1ps

module seq_issue #(
    parameter int cmd_fifo_depth = 4
) (
    input  wire logic                                  rst,  // clock
    input  wire logic                                  mclk, // async reset
    input  wire logic [4:0]                            addr,
    input  wire ps_pio_pkg::cmd_word_t                 data,
    input  wire logic                                  we,
    input  wire logic                                  channel_pgm_en, // grant
    input  wire logic                                  seq_done,
    output logic                                       want_rq,
    output logic                                       need_rq,
    output logic [ps_pio_pkg::seq_addr_bits-1:0]       seq_data,
    output logic                                       seq_set,
    output logic                                       chn_rst,
    output logic                                       busy,
    output logic                                       queue_half,
    output logic [ps_pio_pkg::page_bits-1:0]           head_page,
    output logic                                       head_wr
);

    localparam int aw        = $clog2(cmd_fifo_depth);
    localparam int pend_bits = 4;

    logic [ps_pio_pkg::cmd_bits-1:0] cmd_mem [cmd_fifo_depth];
    logic [aw:0]                     wr_ptr;   // extra bit tells full from empty
    logic [aw:0]                     rd_ptr;
    logic [aw:0]                     fill;
    logic                            nempty;
    logic                            full;
    logic                            push;
    logic                            set_en_rst;
    logic                            set_cmd;
    logic                            chn_en;
    logic                            chn_nrst;
    logic                            short_busy;
    logic                            start;
    logic                            last_wait; // wait bit of last issued cmd
    logic [pend_bits-1:0]            pending;   // issued, not yet done
    ps_pio_pkg::cmd_word_t           head;

    assign set_en_rst = we && (addr == ps_pio_pkg::reg_en_rst);
    assign set_cmd    = we && (addr == ps_pio_pkg::reg_cmd);
    assign fill       = wr_ptr - rd_ptr;
    assign nempty     = fill != '0;
    assign full       = fill[aw];                  // depth is a power of two
    assign queue_half = fill[aw] || fill[aw-1];
    assign push       = set_cmd && !full && !chn_rst;
    assign chn_rst    = !chn_nrst;
    assign head       = {{(32 - ps_pio_pkg::cmd_bits){1'b0}}, cmd_mem[rd_ptr[aw-1:0]]};

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            chn_en   <= 1'b0;  // disabled
            chn_nrst <= 1'b0;  // and in channel reset
        end else if (set_en_rst) begin
            chn_en   <= data.ctl.en;
            chn_nrst <= data.ctl.nrst;
        end
    end

    always_ff @(posedge rst) begin
        if (push) begin
            cmd_mem[wr_ptr[aw-1:0]] <= data[ps_pio_pkg::cmd_bits-1:0];
        end
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (chn_rst) begin
            wr_ptr <= '0;      // flush queue
            rd_ptr <= '0;
        end else begin
            if (push)    wr_ptr <= wr_ptr + 1'b1;
            if (seq_set) rd_ptr <= rd_ptr + 1'b1; // pop issued head
        end
    end

    assign short_busy = want_rq || need_rq || seq_set;
    assign start      = chn_en && !chn_rst && nempty && !short_busy &&
                        ((pending == '0) || !last_wait);

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            want_rq   <= 1'b0;
            need_rq   <= 1'b0;
            seq_set   <= 1'b0;
            last_wait <= 1'b0;
            pending   <= '0;
        end else if (chn_rst) begin
            want_rq   <= 1'b0;
            need_rq   <= 1'b0;
            seq_set   <= 1'b0;
            last_wait <= 1'b0;
            pending   <= '0;
        end else begin
            seq_set <= channel_pgm_en;   // hand-off one cycle after grant
            if (channel_pgm_en) begin
                want_rq <= 1'b0;
                need_rq <= 1'b0;
            end else if (start) begin
                want_rq <= 1'b1;
                need_rq <= head.cmd.need;
            end
            if (seq_set) last_wait <= head.cmd.cmd_wait;
            if (seq_set && !seq_done) begin
                pending <= pending + 1'b1;
            end else if (!seq_set && seq_done) begin
                pending <= pending - 1'b1;
            end
        end
    end

    assign busy      = nempty || short_busy || (pending != '0);
    assign seq_data  = head.cmd.seq_addr;
    assign head_page = head.cmd.page;   // to page router at grant
    assign head_wr   = head.cmd.wr;

    a_no_full_push: assert property (@(posedge rst) disable iff (mclk)
        (set_cmd && !chn_rst) |-> !full)
        else $error("command write to full queue dropped");

    a_done_pending: assert property (@(posedge rst) disable iff (mclk || chn_rst)
        seq_done |-> (pending != '0))
        else $error("seq_done with no transfer pending");

endmodule

`default_nettype wire

/* verilog/page_router.sv */
/*
 * buffer page router
 * queues page and direction per grant, steers the page to the
 * read or write buffer when the transfer starts
 */
`default_nettype none
`timescale 1ns/1ps

module page_router (
    input  wire logic                                rst,  // clock
    input  wire logic                                mclk, // async reset
    input  wire logic                                chn_rst,
    input  wire logic                                channel_pgm_en,
    input  wire logic [ps_pio_pkg::page_bits-1:0]    head_page,
    input  wire logic                                head_wr,
    input  wire logic                                buf_run,   // transfer start
    output logic [ps_pio_pkg::page_bits-1:0]         rpage,     // write-to-memory buffer
    output logic                                     rpage_set,
    output logic [ps_pio_pkg::page_bits-1:0]         wpage,     // read-from-memory buffer
    output logic                                     wpage_set,
    output logic                                     page_nempty
);

    localparam int page_depth = 4;
    localparam int pw         = $clog2(page_depth);

    logic [ps_pio_pkg::page_bits:0] page_mem [page_depth]; // {wr, page}
    logic [pw:0]                    wr_ptr;
    logic [pw:0]                    rd_ptr;
    logic [pw:0]                    fill;
    logic                           push;
    logic                           pop;
    logic                           out_wr;
    logic [ps_pio_pkg::page_bits-1:0] out_page;

    assign fill              = wr_ptr - rd_ptr;
    assign page_nempty       = fill != '0;
    assign push              = channel_pgm_en && !fill[pw] && !chn_rst;
    assign pop               = buf_run && page_nempty;
    assign {out_wr, out_page} = page_mem[rd_ptr[pw-1:0]];

    always_ff @(posedge rst) begin
        if (push) begin
            page_mem[wr_ptr[pw-1:0]] <= {head_wr, head_page};
        end
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (chn_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // strobes, exactly one per popped entry
    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            rpage_set <= 1'b0;
            wpage_set <= 1'b0;
        end else begin
            rpage_set <= pop && out_wr;
            wpage_set <= pop && !out_wr;
        end
    end

    always_ff @(posedge rst) begin
        if (pop && out_wr)  rpage <= out_page;
        if (pop && !out_wr) wpage <= out_page;
    end

    a_run_nempty: assert property (@(posedge rst) disable iff (mclk)
        buf_run |-> page_nempty)
        else $error("buf_run with no page queued");

endmodule

`default_nettype wire

/* verilog/status_gen.sv */
/*
 * channel status generator
 * two-byte serial message: register address, then busy/half/page
 * flags with sequence number, sent once or on every change
 */
`default_nettype none
`timescale 1ns/1ps

module status_gen #(
    parameter logic [7:0] status_reg_addr = 8'h02
) (
    input  wire logic       rst,  // clock
    input  wire logic       mclk, // async reset
    input  wire logic [4:0] addr,
    input  wire logic [7:0] data, // control byte of the write
    input  wire logic       we,
    input  wire logic       busy,
    input  wire logic       queue_half,
    input  wire logic       page_nempty,
    input  wire logic       status_start, // receiver took first byte
    output logic [7:0]      status_ad,
    output logic            status_rq
);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_addr = 2'd1; // first byte held
    localparam logic [1:0] st_data = 2'd2; // payload byte, last

    logic [1:0] state;
    logic [4:0] seq_num;
    logic       auto_en;   // mode 3, send on change
    logic       pend;      // one send requested by control write
    logic [2:0] flags;
    logic [2:0] last_sent;
    logic       set_ctrl;
    logic       trigger;

    assign set_ctrl = we && (addr == ps_pio_pkg::reg_status_cntrl);
    assign flags    = {busy, queue_half, page_nempty};
    assign trigger  = pend || (auto_en && (flags != last_sent));

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            auto_en <= 1'b0;
            seq_num <= 5'd0;
            pend    <= 1'b0;
        end else if (set_ctrl) begin
            auto_en <= &data[7:6];
            seq_num <= data[4:0];
            pend    <= data[6];   // modes 1 and 3 send now
        end else if ((state == st_idle) && trigger) begin
            pend <= 1'b0;
        end
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            state     <= st_idle;
            status_rq <= 1'b0;
            status_ad <= 8'h00;
            last_sent <= 3'b000;
        end else begin
            case (state)
                st_idle: if (trigger) begin
                    state     <= st_addr;
                    status_rq <= 1'b1;
                    status_ad <= status_reg_addr;
                end
                st_addr: if (status_start) begin
                    state     <= st_data;
                    status_rq <= 1'b0;
                    status_ad <= {flags, seq_num}; // newest state wins
                    last_sent <= flags;
                end
                default: state <= st_idle;  // payload shown one cycle
            endcase
        end
    end

    a_start_rq: assert property (@(posedge rst) disable iff (mclk)
        status_start |-> status_rq)
        else $error("status_start without pending request");

endmodule

`default_nettype wire

/* verilog/ps_pio_top.sv */
/*
 * programmable i/o channel top
 * command deserializer, issue logic, page router and status
 */
`default_nettype none
`timescale 1ns/1ps

module ps_pio_top #(
    parameter logic [15:0] ps_addr         = 16'h0100,
    parameter logic [15:0] ps_mask         = 16'h03e0,
    parameter logic [7:0]  status_reg_addr = 8'h02,
    parameter int          cmd_fifo_depth  = 4
) (
    input  wire logic                                rst,  // clock
    input  wire logic                                mclk, // async reset
    input  wire logic [7:0]                          ad,
    input  wire logic                                stb,
    output logic [7:0]                               status_ad,
    output logic                                     status_rq,
    input  wire logic                                status_start,
    output logic                                     want_rq,
    output logic                                     need_rq,
    input  wire logic                                channel_pgm_en,
    output logic [ps_pio_pkg::seq_addr_bits-1:0]     seq_data,
    output logic                                     seq_set,
    input  wire logic                                seq_done,
    input  wire logic                                buf_run,
    output logic [ps_pio_pkg::page_bits-1:0]         rpage,
    output logic                                     rpage_set,
    output logic [ps_pio_pkg::page_bits-1:0]         wpage,
    output logic                                     wpage_set
);

    wire logic [4:0]                       cmd_addr;
    wire ps_pio_pkg::cmd_word_t            cmd_data;
    wire logic                             cmd_we;
    wire logic                             chn_rst;
    wire logic                             busy;
    wire logic                             queue_half;
    wire logic                             page_nempty;
    wire logic [ps_pio_pkg::page_bits-1:0] head_page;
    wire logic                             head_wr;

    cmd_deser #(.ps_addr(ps_addr), .ps_mask(ps_mask)) i_cmd_deser (
        .rst(rst), .mclk(mclk), .ad(ad), .stb(stb),
        .addr(cmd_addr), .data(cmd_data), .we(cmd_we)
    );

    seq_issue #(.cmd_fifo_depth(cmd_fifo_depth)) i_seq_issue (
        .rst(rst), .mclk(mclk), .addr(cmd_addr), .data(cmd_data), .we(cmd_we),
        .channel_pgm_en(channel_pgm_en), .seq_done(seq_done),
        .want_rq(want_rq), .need_rq(need_rq), .seq_data(seq_data), .seq_set(seq_set),
        .chn_rst(chn_rst), .busy(busy), .queue_half(queue_half),
        .head_page(head_page), .head_wr(head_wr)
    );

    page_router i_page_router (
        .rst(rst), .mclk(mclk), .chn_rst(chn_rst), .channel_pgm_en(channel_pgm_en),
        .head_page(head_page), .head_wr(head_wr), .buf_run(buf_run),
        .rpage(rpage), .rpage_set(rpage_set), .wpage(wpage), .wpage_set(wpage_set),
        .page_nempty(page_nempty)
    );

    status_gen #(.status_reg_addr(status_reg_addr)) i_status_gen (
        .rst(rst), .mclk(mclk), .addr(cmd_addr), .data(cmd_data[7:0]), .we(cmd_we),
        .busy(busy), .queue_half(queue_half), .page_nempty(page_nempty),
        .status_start(status_start), .status_ad(status_ad), .status_rq(status_rq)
    );

endmodule

`default_nettype wire

/* tests/ps_pio_tb.sv */
/*
 * testbench for the programmable i/o channel
 * command table applied in a loop, model arbiter with random grant delay,
 * page routing, address filter, status message and channel reset checks
 */
`default_nettype none
`timescale 1ns/1ps

module ps_pio_tb;

    localparam logic [15:0] base_addr   = 16'h0100;
    localparam logic [15:0] addr_mask   = 16'h03e0;
    localparam logic [7:0]  status_addr = 8'h5a;
    localparam int          n_rows      = 5;
    localparam int          wait_limit  = 50;  // cycles per handshake wait
    localparam int          sig_want    = 0;
    localparam int          sig_status  = 1;
    localparam int          sig_page    = 2;

    typedef struct packed {
        logic [9:0] seq_addr;
        logic [1:0] page;
        logic       need;
        logic       wr;
        logic       cmd_wait;
        logic [9:0] exp_seq_data;
        logic       exp_need;
        logic [1:0] exp_page;
        logic       exp_rset;  // 1 rpage_set, 0 wpage_set
        logic       exp_held;  // request held until earlier transfers done
    } row_t;

    logic       rst;   // clock
    logic       mclk;  // reset, active high
    logic [7:0] ad;
    logic       stb;
    logic [7:0] status_ad;
    logic       status_rq;
    logic       status_start;
    logic       want_rq;
    logic       need_rq;
    logic       channel_pgm_en;
    logic [9:0] seq_data;
    logic       seq_set;
    logic       seq_done;
    logic       buf_run;
    logic [1:0] rpage;
    logic       rpage_set;
    logic [1:0] wpage;
    logic       wpage_set;
    row_t       rows [n_rows];
    int         pending_cnt;  // issued transfers without seq_done
    int         seed_val;

    ps_pio_top #(
        .ps_addr(base_addr), .ps_mask(addr_mask),
        .status_reg_addr(status_addr), .cmd_fifo_depth(4)
    ) i_dut (
        .rst(rst), .mclk(mclk), .ad(ad), .stb(stb),
        .status_ad(status_ad), .status_rq(status_rq), .status_start(status_start),
        .want_rq(want_rq), .need_rq(need_rq), .channel_pgm_en(channel_pgm_en),
        .seq_data(seq_data), .seq_set(seq_set), .seq_done(seq_done), .buf_run(buf_run),
        .rpage(rpage), .rpage_set(rpage_set), .wpage(wpage), .wpage_set(wpage_set)
    );

    always #5 rst = ~rst;  // 10 ns period

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    // poll at the falling edge, outputs settled
    task automatic wait_signal(input int which, input string name);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < wait_limit) begin
            @(negedge rst);
            case (which)
                sig_want:   seen = want_rq;
                sig_status: seen = status_rq;
                default:    seen = rpage_set | wpage_set;
            endcase
            n++;
        end
        if (!seen) begin
            $display("timeout: %s did not go high within %0d cycles", name, wait_limit);
            $display("Finished with errors");
            $fatal(1, "handshake timeout");
        end
    endtask

    task automatic expect_quiet(input int cycles);
        for (int k = 0; k < cycles; k++) begin
            @(negedge rst);
            check_equal("want_rq", want_rq, 1'b0);
        end
    endtask

    // address low, address high, data bytes 0..3
    task automatic send_write(input logic [15:0] a, input logic [31:0] d);
        logic [47:0] bytes;
        bytes = {d, a};
        for (int k = 0; k < 6; k++) begin
            @(posedge rst);
            ad  <= bytes[k*8 +: 8];
            stb <= (k == 0);  // first byte only
        end
        @(posedge rst);
        ad  <= 8'h00;
        stb <= 1'b0;
    endtask

    task automatic finish_transfers();
        while (pending_cnt > 0) begin
            @(posedge rst);
            seq_done <= 1'b1;
            @(posedge rst);
            seq_done <= 1'b0;
            pending_cnt--;
        end
    endtask

    task automatic read_status(input logic [7:0] exp_payload);
        wait_signal(sig_status, "status_rq");
        check_equal("status_ad", status_ad, status_addr);  // first byte
        @(posedge rst);
        status_start <= 1'b1;
        @(posedge rst);
        status_start <= 1'b0;
        @(negedge rst);
        check_equal("status_rq", status_rq, 1'b0);
        check_equal("status_ad", status_ad, exp_payload);
    endtask

    task automatic run_row(input row_t r);
        ps_pio_pkg::cmd_word_t w;
        int                    delay;
        w              = '0;
        w.cmd.seq_addr = r.seq_addr;
        w.cmd.page     = r.page;
        w.cmd.need     = r.need;
        w.cmd.wr       = r.wr;
        w.cmd.cmd_wait = r.cmd_wait;
        send_write(base_addr | 16'(ps_pio_pkg::reg_cmd), w);
        if (r.exp_held) begin
            expect_quiet(8);     // previous command had wait set
            finish_transfers();
        end
        wait_signal(sig_want, "want_rq");
        check_equal("need_rq", need_rq, r.exp_need);
        delay = $urandom % 4;   // arbiter response time
        repeat (delay) @(posedge rst);
        @(posedge rst);
        channel_pgm_en <= 1'b1;
        @(posedge rst);
        channel_pgm_en <= 1'b0;
        @(negedge rst);
        check_equal("seq_set", seq_set, 1'b1);
        check_equal("seq_data", seq_data, r.exp_seq_data);
        check_equal("want_rq", want_rq, 1'b0);
        check_equal("need_rq", need_rq, 1'b0);
        pending_cnt++;
        @(posedge rst);
        buf_run <= 1'b1;        // transfer starts
        @(posedge rst);
        buf_run <= 1'b0;
        wait_signal(sig_page, "page set strobe");
        check_equal("rpage_set", rpage_set, r.exp_rset);
        check_equal("wpage_set", wpage_set, !r.exp_rset);
        if (r.exp_rset) check_equal("rpage", rpage, r.exp_page);
        else check_equal("wpage", wpage, r.exp_page);
    endtask

    initial begin
        ps_pio_pkg::cmd_word_t w;
        seed_val       = $urandom(45);
        rst            = 1'b0;
        mclk           = 1'b1;
        ad             = 8'h00;
        stb            = 1'b0;
        status_start   = 1'b0;
        channel_pgm_en = 1'b0;
        seq_done       = 1'b0;
        buf_run        = 1'b0;
        pending_cnt    = 0;
        //         addr    pg    need  wr    wait  exp_data pg_need pg   rset  held
        rows[0] = '{10'h155, 2'd1, 1'b0, 1'b1, 1'b0, 10'h155, 1'b0, 2'd1, 1'b1, 1'b0};
        rows[1] = '{10'h2a3, 2'd2, 1'b1, 1'b0, 1'b1, 10'h2a3, 1'b1, 2'd2, 1'b0, 1'b0};
        rows[2] = '{10'h07f, 2'd3, 1'b0, 1'b0, 1'b0, 10'h07f, 1'b0, 2'd3, 1'b0, 1'b1};
        rows[3] = '{10'h3c0, 2'd0, 1'b1, 1'b1, 1'b1, 10'h3c0, 1'b1, 2'd0, 1'b1, 1'b0};
        rows[4] = '{10'h011, 2'd2, 1'b0, 1'b1, 1'b0, 10'h011, 1'b0, 2'd2, 1'b1, 1'b1};
        repeat (5) @(posedge rst);
        mclk <= 1'b0;
        @(negedge rst);
        check_equal("want_rq", want_rq, 1'b0);
        check_equal("need_rq", need_rq, 1'b0);
        check_equal("seq_set", seq_set, 1'b0);
        check_equal("rpage_set", rpage_set, 1'b0);
        check_equal("wpage_set", wpage_set, 1'b0);
        check_equal("status_rq", status_rq, 1'b0);
        send_write(base_addr | 16'(ps_pio_pkg::reg_en_rst), 32'h3);  // enable, out of reset
        for (int i = 0; i < n_rows; i++) begin
            run_row(rows[i]);
        end
        // bit 5 lies inside the mask, so this write misses the window
        w              = '0;
        w.cmd.seq_addr = 10'h3ff;
        send_write((base_addr ^ 16'h0020) | 16'(ps_pio_pkg::reg_cmd), w);
        expect_quiet(20);
        finish_transfers();
        // disabled channel keeps two commands queued
        send_write(base_addr | 16'(ps_pio_pkg::reg_en_rst), 32'h1);
        send_write(base_addr | 16'(ps_pio_pkg::reg_cmd), w);
        send_write(base_addr | 16'(ps_pio_pkg::reg_cmd), w);
        send_write(base_addr | 16'(ps_pio_pkg::reg_status_cntrl), 32'h55);  // single, seq 15
        read_status({1'b1, 1'b1, 1'b0, 5'h15});  // busy, half full, no pages
        // channel reset flushes the queue
        send_write(base_addr | 16'(ps_pio_pkg::reg_en_rst), 32'h0);
        send_write(base_addr | 16'(ps_pio_pkg::reg_en_rst), 32'h3);
        expect_quiet(20);
        send_write(base_addr | 16'(ps_pio_pkg::reg_status_cntrl), 32'h4a);  // single, seq 0a
        read_status({3'b000, 5'h0a});
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
verilog/ps_pio_pkg.sv
verilog/cmd_deser.sv
verilog/seq_issue.sv
verilog/page_router.sv
verilog/status_gen.sv
verilog/ps_pio_top.sv
tests/ps_pio_tb.sv

/* run.sh */
#!/bin/sh
# build the channel testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module ps_pio_tb \
    -o ps_pio_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/ps_pio_sim 2>&1)
echo "$out"
echo "$out" | grep -q "Finished with no errors" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
